/* hw/bitmanip_pkg.sv */
// shared widths, operation codes and request type for the bit-manipulation co-processor
// every design file pulls what it needs from here with scoped names

package bitmanip_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int xlen_c    = 32; // datapath width
  localparam int shamt_w_c = 5;  // shift amount, log2(xlen_c)
  localparam int cnt_w_c   = 6;  // counters up to and including 32

  localparam logic [cnt_w_c-1:0] cnt_full_c = cnt_w_c'(xlen_c); // full word of iterations

  // operation codes, already decoded by the caller
  typedef enum logic [4:0] {
    op_andn, op_orn, op_xnor,             // zbb logic with negate
    op_min, op_minu, op_max, op_maxu,     // zbb min/max
    op_sext_b, op_sext_h, op_zext_h,      // zbb extension
    op_orc_b, op_rev8,                    // zbb byte ops
    op_clz, op_ctz, op_cpop,              // zbb counts, serial
    op_rol, op_ror, op_rori,              // zbb rotates, serial
    op_sh1add, op_sh2add, op_sh3add,      // zba
    op_bclr, op_bext, op_binv, op_bset,   // zbs
    op_clmul, op_clmulh, op_clmulr        // zbc, serial
  } bm_op_e;

  // one request as handed over with start
  typedef struct packed {
    bm_op_e                op;
    logic [xlen_c-1:0]     rs1;
    logic [xlen_c-1:0]     rs2;
    logic [shamt_w_c-1:0]  shamt; // rotate amount / bit index
  } bm_req_t;

  // unit that owns the result
  typedef enum logic [1:0] {
    cls_alu,
    cls_shift,
    cls_clmul
  } bm_class_e;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic bm_class_e op_class_f(input bm_op_e op);
    case (op)
      op_clz, op_ctz, op_cpop,
      op_rol, op_ror, op_rori:          return cls_shift;
      op_clmul, op_clmulh, op_clmulr:   return cls_clmul;
      default:                          return cls_alu; // single cycle
    endcase
  endfunction

  // mirror bit order, lets the units shift right only
  function automatic logic [xlen_c-1:0] bit_rev_f(input logic [xlen_c-1:0] din);
    logic [xlen_c-1:0] dout;
    for (int i = 0; i < xlen_c; i++) begin
      dout[i] = din[xlen_c-1-i];
    end
    return dout;
  endfunction

endpackage

/* hw/bitmanip_ctrl.sv */
// control FSM of the co-processor, registers the request and kicks the serial units
// alu-class ops finish right away, shift and clmul ops wait for the unit to drop busy

`timescale 1ns/1ps

module bitmanip_ctrl (
  input  logic                  clk_i,
  input  logic                  rstn_i,         // async, active low
  input  logic                  start_i,        // one-cycle strobe
  input  bitmanip_pkg::bm_req_t req_i,
  output bitmanip_pkg::bm_req_t req_o,          // registered request to all units
  output logic                  shift_start_o,  // pulse, shifter loads on it
  output logic                  clmul_start_o,  // pulse, multiplier loads on it
  input  logic                  shift_busy_i,
  input  logic                  clmul_busy_i,
  output logic                  done_o          // pulse, result stage captures
);

  typedef enum logic [2:0] {
    st_idle,
    st_start_shift,
    st_busy_shift,
    st_start_clmul,
    st_busy_clmul
  } ctrl_state_e;

  ctrl_state_e           state_q;
  bitmanip_pkg::bm_req_t req_q;
  logic                  shift_start_q;
  logic                  clmul_start_q;
  logic                  done_q;
  logic                  accept;

  assign accept = start_i && (state_q == st_idle); // starts while busy are dropped

  // request register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q       <= st_idle;
      shift_start_q <= 1'b0;
      clmul_start_q <= 1'b0;
      done_q        <= 1'b0;
    end else begin
      shift_start_q <= 1'b0; // pulses by default
      clmul_start_q <= 1'b0;
      done_q        <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            case (bitmanip_pkg::op_class_f(req_i.op))
              bitmanip_pkg::cls_shift: begin
                shift_start_q <= 1'b1;
                state_q       <= st_start_shift;
              end
              bitmanip_pkg::cls_clmul: begin
                clmul_start_q <= 1'b1;
                state_q       <= st_start_clmul;
              end
              default: done_q <= 1'b1; // alu result valid next cycle
            endcase
          end
        end
        st_start_shift: state_q <= st_busy_shift; // unit loads this edge
        st_busy_shift: begin
          if (!shift_busy_i) begin
            done_q  <= 1'b1;
            state_q <= st_idle;
          end
        end
        st_start_clmul: state_q <= st_busy_clmul;
        st_busy_clmul: begin
          if (!clmul_busy_i) begin
            done_q  <= 1'b1;
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign req_o         = req_q;
  assign shift_start_o = shift_start_q;
  assign clmul_start_o = clmul_start_q;
  assign done_o        = done_q;

endmodule

/* hw/bitmanip_shifter.sv */
// iterative right shifter for clz, ctz, cpop and the rotates
// one bit per cycle, left-hand ops run on the bit-reversed operand

`timescale 1ns/1ps

module bitmanip_shifter (
  input  logic                                clk_i,
  input  logic                                start_i, // load operand
  input  bitmanip_pkg::bm_req_t               req_i,   // held stable while running
  output logic                                busy_o,
  output logic [bitmanip_pkg::xlen_c-1:0]     res_o
);

  logic [bitmanip_pkg::xlen_c-1:0]  sreg_q;    // shift register
  logic [bitmanip_pkg::cnt_w_c-1:0] cnt_q;     // iterations done
  logic [bitmanip_pkg::cnt_w_c-1:0] bcnt_q;    // one bits seen
  logic [bitmanip_pkg::cnt_w_c-1:0] cnt_max_q; // stop value for rotate / cpop
  logic                             is_count;  // clz or ctz
  logic                             is_rot;
  logic                             run;
  logic                             new_bit;

  assign is_count = (req_i.op == bitmanip_pkg::op_clz) || (req_i.op == bitmanip_pkg::op_ctz);
  assign is_rot   = (req_i.op == bitmanip_pkg::op_rol) || (req_i.op == bitmanip_pkg::op_ror) ||
                    (req_i.op == bitmanip_pkg::op_rori);

  // counts stop at the first one, a fed-in one ends a zero operand after 32
  assign run     = is_count ? !sreg_q[0] : (cnt_q != cnt_max_q);
  assign new_bit = is_rot ? sreg_q[0] : is_count; // rotate wraps, cpop shifts in zero
  assign busy_o  = run;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cnt_q  <= '0;
      bcnt_q <= '0;
      if ((req_i.op == bitmanip_pkg::op_clz) || (req_i.op == bitmanip_pkg::op_rol)) begin
        sreg_q <= bitmanip_pkg::bit_rev_f(req_i.rs1); // left turned into right
      end else begin
        sreg_q <= req_i.rs1;
      end
      if (req_i.op == bitmanip_pkg::op_cpop) begin
        cnt_max_q <= bitmanip_pkg::cnt_full_c; // walk the whole word
      end else begin
        cnt_max_q <= {1'b0, req_i.shamt};
      end
    end else if (run) begin
      sreg_q <= {new_bit, sreg_q[bitmanip_pkg::xlen_c-1:1]};
      cnt_q  <= cnt_q + 1'b1;
      if (sreg_q[0]) begin
        bcnt_q <= bcnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // result
  // --------------------------------------------------
  always_comb begin
    res_o = '0;
    case (req_i.op)
      bitmanip_pkg::op_clz,
      bitmanip_pkg::op_ctz:  res_o[bitmanip_pkg::cnt_w_c-1:0] = cnt_q;  // zeros skipped
      bitmanip_pkg::op_cpop: res_o[bitmanip_pkg::cnt_w_c-1:0] = bcnt_q;
      bitmanip_pkg::op_ror,
      bitmanip_pkg::op_rori: res_o = sreg_q;
      bitmanip_pkg::op_rol:  res_o = bitmanip_pkg::bit_rev_f(sreg_q); // undo input mirror
      default:               res_o = '0;
    endcase
  end

endmodule

/* hw/bitmanip_clmul.sv */
// iterative carry-less multiplier, 32 shift-and-xor steps into a 64-bit product
// clmulr is built from the low half of the product of both reversed operands

`timescale 1ns/1ps

module bitmanip_clmul (
  input  logic                              clk_i,
  input  logic                              start_i, // load operands
  input  bitmanip_pkg::bm_req_t             req_i,   // held stable while running
  output logic                              busy_o,
  output logic [bitmanip_pkg::xlen_c-1:0]   res_o
);

  logic [2*bitmanip_pkg::xlen_c-1:0] prod_q;   // hi: partial sum, lo: multiplier bits
  logic [bitmanip_pkg::cnt_w_c-1:0]  cnt_q;    // steps left
  logic [bitmanip_pkg::xlen_c-1:0]   rs2_v;    // multiplicand, maybe mirrored
  logic [bitmanip_pkg::xlen_c-1:0]   hi_next;
  logic                              rev_ops;

  assign rev_ops = (req_i.op == bitmanip_pkg::op_clmulr);
  assign rs2_v   = rev_ops ? bitmanip_pkg::bit_rev_f(req_i.rs2) : req_i.rs2;
  assign busy_o  = |cnt_q;

  // xor in the multiplicand when the current multiplier bit is set
  assign hi_next = prod_q[0] ? (prod_q[2*bitmanip_pkg::xlen_c-1:bitmanip_pkg::xlen_c] ^ rs2_v)
                             :  prod_q[2*bitmanip_pkg::xlen_c-1:bitmanip_pkg::xlen_c];

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cnt_q <= bitmanip_pkg::cnt_full_c;
      if (rev_ops) begin
        prod_q <= {{bitmanip_pkg::xlen_c{1'b0}}, bitmanip_pkg::bit_rev_f(req_i.rs1)};
      end else begin
        prod_q <= {{bitmanip_pkg::xlen_c{1'b0}}, req_i.rs1};
      end
    end else if (busy_o) begin
      cnt_q  <= cnt_q - 1'b1;
      prod_q <= {1'b0, hi_next, prod_q[bitmanip_pkg::xlen_c-1:1]}; // shift right by one
    end
  end

  // --------------------------------------------------
  // result select
  // --------------------------------------------------
  always_comb begin
    case (req_i.op)
      bitmanip_pkg::op_clmul:  res_o = prod_q[bitmanip_pkg::xlen_c-1:0];
      bitmanip_pkg::op_clmulh: res_o = prod_q[2*bitmanip_pkg::xlen_c-1:bitmanip_pkg::xlen_c];
      bitmanip_pkg::op_clmulr: res_o = bitmanip_pkg::bit_rev_f(prod_q[bitmanip_pkg::xlen_c-1:0]);
      default:                 res_o = '0;
    endcase
  end

endmodule

/* hw/bitmanip_alu.sv */
// single-cycle results: logic, min/max, extension, byte ops, shifted add and single-bit ops
// purely combinational off the registered request

`timescale 1ns/1ps

module bitmanip_alu (
  input  bitmanip_pkg::bm_req_t             req_i,
  output logic [bitmanip_pkg::xlen_c-1:0]   res_o
);

  logic [bitmanip_pkg::xlen_c-1:0] rs1;
  logic [bitmanip_pkg::xlen_c-1:0] rs2;
  logic [bitmanip_pkg::xlen_c-1:0] one_hot;  // bit index decoded
  logic [bitmanip_pkg::xlen_c-1:0] orc_b;
  logic [bitmanip_pkg::xlen_c-1:0] rev8;
  logic [bitmanip_pkg::xlen_c-1:0] sh_opa;   // rs1 pre-shifted for shadd
  logic                            lt_s;     // signed less than
  logic                            lt_u;     // unsigned less than

  assign rs1 = req_i.rs1;
  assign rs2 = req_i.rs2;

  assign lt_s    = $signed(rs1) < $signed(rs2);
  assign lt_u    = rs1 < rs2;
  assign one_hot = {{(bitmanip_pkg::xlen_c-1){1'b0}}, 1'b1} << req_i.shamt;

  // --------------------------------------------------
  // byte-wise helpers
  // --------------------------------------------------
  always_comb begin
    for (int b = 0; b < bitmanip_pkg::xlen_c/8; b++) begin
      orc_b[b*8 +: 8] = {8{|rs1[b*8 +: 8]}};                               // any bit set
      rev8[b*8 +: 8]  = rs1[(bitmanip_pkg::xlen_c/8-1-b)*8 +: 8];          // byte swap
    end
  end

  // shift amount of shadd taken from the op itself
  always_comb begin
    case (req_i.op)
      bitmanip_pkg::op_sh1add: sh_opa = {rs1[bitmanip_pkg::xlen_c-2:0], 1'b0};
      bitmanip_pkg::op_sh2add: sh_opa = {rs1[bitmanip_pkg::xlen_c-3:0], 2'b0};
      default:                 sh_opa = {rs1[bitmanip_pkg::xlen_c-4:0], 3'b0}; // sh3add
    endcase
  end

  // --------------------------------------------------
  // result select
  // --------------------------------------------------
  always_comb begin
    case (req_i.op)
      bitmanip_pkg::op_andn:   res_o = rs1 & ~rs2;
      bitmanip_pkg::op_orn:    res_o = rs1 | ~rs2;
      bitmanip_pkg::op_xnor:   res_o = rs1 ^ ~rs2;
      bitmanip_pkg::op_min:    res_o = lt_s ? rs1 : rs2;
      bitmanip_pkg::op_minu:   res_o = lt_u ? rs1 : rs2;
      bitmanip_pkg::op_max:    res_o = lt_s ? rs2 : rs1;
      bitmanip_pkg::op_maxu:   res_o = lt_u ? rs2 : rs1;
      bitmanip_pkg::op_sext_b: res_o = {{(bitmanip_pkg::xlen_c-8){rs1[7]}}, rs1[7:0]};
      bitmanip_pkg::op_sext_h: res_o = {{(bitmanip_pkg::xlen_c-16){rs1[15]}}, rs1[15:0]};
      bitmanip_pkg::op_zext_h: res_o = {{(bitmanip_pkg::xlen_c-16){1'b0}}, rs1[15:0]};
      bitmanip_pkg::op_orc_b:  res_o = orc_b;
      bitmanip_pkg::op_rev8:   res_o = rev8;
      bitmanip_pkg::op_sh1add,
      bitmanip_pkg::op_sh2add,
      bitmanip_pkg::op_sh3add: res_o = rs2 + sh_opa; // address generation
      bitmanip_pkg::op_bclr:   res_o = rs1 & ~one_hot;
      bitmanip_pkg::op_bext:   res_o = {{(bitmanip_pkg::xlen_c-1){1'b0}}, |(rs1 & one_hot)};
      bitmanip_pkg::op_binv:   res_o = rs1 ^ one_hot;
      bitmanip_pkg::op_bset:   res_o = rs1 | one_hot;
      default:                 res_o = '0; // serial ops come from their own unit
    endcase
  end

endmodule

/* hw/bitmanip_result.sv */
// output stage, picks the owning unit's result and holds it for one cycle on done
// res_o stays zero whenever valid_o is low

`timescale 1ns/1ps

module bitmanip_result (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              done_i,      // capture strobe
  input  bitmanip_pkg::bm_op_e              op_i,
  input  logic [bitmanip_pkg::xlen_c-1:0]   alu_res_i,
  input  logic [bitmanip_pkg::xlen_c-1:0]   shift_res_i,
  input  logic [bitmanip_pkg::xlen_c-1:0]   clmul_res_i,
  output logic [bitmanip_pkg::xlen_c-1:0]   res_o,
  output logic                              valid_o
);

  logic [bitmanip_pkg::xlen_c-1:0] res_sel;

  always_comb begin
    case (bitmanip_pkg::op_class_f(op_i))
      bitmanip_pkg::cls_shift: res_sel = shift_res_i;
      bitmanip_pkg::cls_clmul: res_sel = clmul_res_i;
      default:                 res_sel = alu_res_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= done_i;
      res_o   <= done_i ? res_sel : '0; // gated, one cycle only
    end
  end

endmodule

/* hw/bitmanip_top.sv */
// top of the bit-manipulation co-processor: decoded op plus operands in, result and valid out
// one operation in flight, start is ignored until valid_o has pulsed

`timescale 1ns/1ps

module bitmanip_top (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              start_i,
  input  bitmanip_pkg::bm_req_t             req_i,
  output logic [bitmanip_pkg::xlen_c-1:0]   res_o,
  output logic                              valid_o
);

  bitmanip_pkg::bm_req_t           req_q;       // registered request
  logic                            shift_start;
  logic                            clmul_start;
  logic                            shift_busy;
  logic                            clmul_busy;
  logic                            done;
  logic [bitmanip_pkg::xlen_c-1:0] shift_res;
  logic [bitmanip_pkg::xlen_c-1:0] clmul_res;
  logic [bitmanip_pkg::xlen_c-1:0] alu_res;

  // --------------------------------------------------
  // control and units
  // --------------------------------------------------
  bitmanip_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_i       (start_i),
    .req_i         (req_i),
    .req_o         (req_q),
    .shift_start_o (shift_start),
    .clmul_start_o (clmul_start),
    .shift_busy_i  (shift_busy),
    .clmul_busy_i  (clmul_busy),
    .done_o        (done)
  );

  bitmanip_shifter i_shifter (
    .clk_i   (clk_i),
    .start_i (shift_start),
    .req_i   (req_q),
    .busy_o  (shift_busy),
    .res_o   (shift_res)
  );

  bitmanip_clmul i_clmul (
    .clk_i   (clk_i),
    .start_i (clmul_start),
    .req_i   (req_q),
    .busy_o  (clmul_busy),
    .res_o   (clmul_res)
  );

  bitmanip_alu i_alu (
    .req_i (req_q),
    .res_o (alu_res)
  );

  // output register
  bitmanip_result i_result (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .done_i      (done),
    .op_i        (req_q.op),
    .alu_res_i   (alu_res),
    .shift_res_i (shift_res),
    .clmul_res_i (clmul_res),
    .res_o       (res_o),
    .valid_o     (valid_o)
  );

endmodule

/* test/tb_bitmanip.sv */
// testbench for the bit-manipulation co-processor, random requests checked against a model
// compiled through project.f, prints one line per test and a closing summary

`timescale 1ns/1ps

module tb_bitmanip;

  localparam int seed_c        = 41620;
  localparam int alu_reps_c    = 8;   // per alu-class op
  localparam int shift_reps_c  = 6;   // random ones, zero and all ones come on top
  localparam int clmul_reps_c  = 10;
  localparam int poke_ops_c    = 12;  // serial ops with a start while busy
  localparam int op_cycles_c   = 50;  // per-op limit
  localparam int total_ops_c   = 19 * alu_reps_c + 6 * (shift_reps_c + 2) +
                                 3 * clmul_reps_c + poke_ops_c + 1;
  localparam int watchdog_ns_c = total_ops_c * 60 * 100;

  localparam bitmanip_pkg::bm_op_e alu_ops_c [19] = '{
    bitmanip_pkg::op_andn, bitmanip_pkg::op_orn, bitmanip_pkg::op_xnor,
    bitmanip_pkg::op_min, bitmanip_pkg::op_minu, bitmanip_pkg::op_max, bitmanip_pkg::op_maxu,
    bitmanip_pkg::op_sext_b, bitmanip_pkg::op_sext_h, bitmanip_pkg::op_zext_h,
    bitmanip_pkg::op_orc_b, bitmanip_pkg::op_rev8,
    bitmanip_pkg::op_sh1add, bitmanip_pkg::op_sh2add, bitmanip_pkg::op_sh3add,
    bitmanip_pkg::op_bclr, bitmanip_pkg::op_bext, bitmanip_pkg::op_binv, bitmanip_pkg::op_bset
  };
  localparam bitmanip_pkg::bm_op_e shift_ops_c [6] = '{
    bitmanip_pkg::op_clz, bitmanip_pkg::op_ctz, bitmanip_pkg::op_cpop,
    bitmanip_pkg::op_rol, bitmanip_pkg::op_ror, bitmanip_pkg::op_rori
  };
  localparam bitmanip_pkg::bm_op_e clmul_ops_c [3] = '{
    bitmanip_pkg::op_clmul, bitmanip_pkg::op_clmulh, bitmanip_pkg::op_clmulr
  };

  logic                            clk_i;
  logic                            rstn_i;
  logic                            start_i;
  bitmanip_pkg::bm_req_t           req_i;
  logic [bitmanip_pkg::xlen_c-1:0] res_o;
  logic                            valid_o;
  int                              errors    = 0;
  int                              checks    = 0;
  int                              pulse_cnt = 0; // valid_o pulses since last check

  bitmanip_top i_bitmanip_top (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (start_i),
    .req_i   (req_i),
    .res_o   (res_o),
    .valid_o (valid_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i; // 100 ns period

  // --------------------------------------------------
  // reference model, straight from the instruction rules
  // --------------------------------------------------
  function automatic logic [31:0] model_f(input bitmanip_pkg::bm_req_t r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] y;
    logic [63:0] prod; // full carry-less product
    int          sh;
    int          n;
    a    = r.rs1;
    b    = r.rs2;
    sh   = int'(r.shamt);
    y    = '0;
    prod = '0;
    n    = 0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) prod = prod ^ ({32'h0, a} << i);
    end
    case (r.op)
      bitmanip_pkg::op_andn:   y = a & ~b;
      bitmanip_pkg::op_orn:    y = a | ~b;
      bitmanip_pkg::op_xnor:   y = ~(a ^ b);
      bitmanip_pkg::op_min:    y = ($signed(a) > $signed(b)) ? b : a;
      bitmanip_pkg::op_minu:   y = (a > b) ? b : a;
      bitmanip_pkg::op_max:    y = ($signed(a) > $signed(b)) ? a : b;
      bitmanip_pkg::op_maxu:   y = (a > b) ? a : b;
      bitmanip_pkg::op_sext_b: y = {{24{a[7]}}, a[7:0]};
      bitmanip_pkg::op_sext_h: y = {{16{a[15]}}, a[15:0]};
      bitmanip_pkg::op_zext_h: y = a & 32'h0000_ffff;
      bitmanip_pkg::op_orc_b: begin
        for (int k = 0; k < 4; k++) y[8*k +: 8] = (a[8*k +: 8] != 8'h0) ? 8'hff : 8'h00;
      end
      bitmanip_pkg::op_rev8:   y = {a[7:0], a[15:8], a[23:16], a[31:24]};
      bitmanip_pkg::op_sh1add: y = b + (a << 1);
      bitmanip_pkg::op_sh2add: y = b + (a << 2);
      bitmanip_pkg::op_sh3add: y = b + (a << 3);
      bitmanip_pkg::op_bclr:   y = a & ~(32'h1 << sh);
      bitmanip_pkg::op_bext:   y = (a >> sh) & 32'h1;
      bitmanip_pkg::op_binv:   y = a ^ (32'h1 << sh);
      bitmanip_pkg::op_bset:   y = a | (32'h1 << sh);
      bitmanip_pkg::op_clz: begin
        while (n < 32 && a[31-n] == 1'b0) n++; // scan from the msb
        y = 32'(n);
      end
      bitmanip_pkg::op_ctz: begin
        while (n < 32 && a[n] == 1'b0) n++;
        y = 32'(n);
      end
      bitmanip_pkg::op_cpop: begin
        for (int k = 0; k < 32; k++) n = n + int'(a[k]);
        y = 32'(n);
      end
      bitmanip_pkg::op_rol:    y = (a << sh) | (a >> (32 - sh)); // sh 0 gives a
      bitmanip_pkg::op_ror,
      bitmanip_pkg::op_rori:   y = (a >> sh) | (a << (32 - sh));
      bitmanip_pkg::op_clmul:  y = prod[31:0];
      bitmanip_pkg::op_clmulh: y = prod[63:32];
      bitmanip_pkg::op_clmulr: y = prod[62:31];
      default:                 y = '0;
    endcase
    return y;
  endfunction

  function automatic bitmanip_pkg::bm_req_t rand_req(input bitmanip_pkg::bm_op_e op);
    bitmanip_pkg::bm_req_t r;
    r.op    = op;
    r.rs1   = $urandom;
    r.rs2   = $urandom;
    r.shamt = 5'($urandom);
    return r;
  endfunction

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // no data outside a pulse, pulse lasts one cycle
  assert property (@(posedge clk_i) disable iff (!rstn_i) !valid_o |-> (res_o == '0))
    else begin
      $display("** Error at %0d ns: res_o = %h, expected %h while valid_o low",
               $time, $sampled(res_o), 32'h0);
      errors++;
    end
  assert property (@(posedge clk_i) disable iff (!rstn_i) valid_o |=> !valid_o)
    else begin
      $display("** Error at %0d ns: valid_o = 1, expected 0 after a pulse", $time);
      errors++;
    end

  always @(negedge clk_i) begin
    if (rstn_i && valid_o) pulse_cnt++; // outputs settled mid-cycle
  end

  // one request, start driven 10 ns after the edge, optional start while busy
  task automatic check_op(input bitmanip_pkg::bm_req_t req, input int want_lat,
                          input bit poke, output logic [31:0] res);
    logic [31:0] exp;
    int          cyc;
    exp = model_f(req);
    cyc = 0;
    res = '0;
    @(posedge clk_i);
    #10;
    req_i   = req;
    start_i = 1'b1;
    do begin
      @(posedge clk_i);
      #10;
      cyc++;
      start_i = poke && (cyc == 2); // fsm is busy here
      if (poke && cyc == 2) req_i = rand_req(bitmanip_pkg::op_andn); // alu op, other class
    end while (!valid_o && cyc < op_cycles_c);
    checks++;
    if (!valid_o) begin
      $display("%s got no valid_o within %0d cycles", req.op.name(), op_cycles_c);
      errors++;
    end else begin
      res = res_o;
      assert (res_o == exp) else begin
        $display("** Error at %0d ns: res_o = %h, expected %h (%s)",
                 $time, res_o, exp, req.op.name());
        errors++;
      end
      if (want_lat != 0) begin
        assert (cyc == want_lat) else begin
          $display("** Error at %0d ns: valid_o latency = %0d, expected %0d (%s)",
                   $time, cyc, want_lat, req.op.name());
          errors++;
        end
      end
    end
    repeat (2) @(posedge clk_i); // room for a stray second pulse
    assert (pulse_cnt == 1) else begin
      $display("** Error at %0d ns: valid_o pulses = %0d, expected 1", $time, pulse_cnt);
      errors++;
    end
    pulse_cnt = 0;
  endtask

  task automatic report_test(input string name, input int ops, input int err_mark);
    $display("test %-8s ops %4d  errors %0d", name, ops, errors - err_mark);
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    bitmanip_pkg::bm_req_t req;
    logic [31:0]           res;
    int                    err_mark;
    int                    k;
    void'($urandom(seed_c));
    rstn_i     = 1'b0;
    start_i    = 1'b0;
    req_i      = '0;
    repeat (3) @(posedge clk_i);
    #10;
    rstn_i = 1'b1;

    err_mark = errors; // idle outputs after reset
    repeat (4) begin
      @(posedge clk_i);
      #10;
      checks++;
      assert (valid_o == 1'b0 && res_o == '0) else begin
        $display("** Error at %0d ns: valid_o = %b res_o = %h, expected 0 and 0",
                 $time, valid_o, res_o);
        errors++;
      end
    end
    report_test("reset", 0, err_mark);

    err_mark = errors;
    foreach (alu_ops_c[i]) begin
      for (int rep = 0; rep < alu_reps_c; rep++) begin
        req = rand_req(alu_ops_c[i]);
        if (rep == 0) req.shamt = 5'd0;
        if (rep == 1) req.shamt = 5'd31;
        if (rep == 2) req.rs2 = req.rs1; // min/max tie
        check_op(req, 2, 1'b0, res);
      end
    end
    report_test("alu", 19 * alu_reps_c, err_mark);

    err_mark = errors;
    foreach (shift_ops_c[i]) begin
      for (int rep = 0; rep < shift_reps_c + 2; rep++) begin
        req = rand_req(shift_ops_c[i]);
        if (rep == 0) req.rs1 = 32'h0;
        if (rep == 1) req.rs1 = 32'hffff_ffff;
        check_op(req, 0, 1'b0, res);
        if (rep == 0 && (req.op == bitmanip_pkg::op_clz || req.op == bitmanip_pkg::op_ctz)) begin
          assert (res == 32'd32) else begin
            $display("** Error at %0d ns: res_o = %0d, expected 32 (%s of zero)",
                     $time, res, req.op.name());
            errors++;
          end
        end
      end
    end
    report_test("shift", 6 * (shift_reps_c + 2), err_mark);

    err_mark = errors;
    foreach (clmul_ops_c[i]) begin
      for (int rep = 0; rep < clmul_reps_c; rep++) begin
        check_op(rand_req(clmul_ops_c[i]), 0, 1'b0, res);
      end
    end
    report_test("clmul", 3 * clmul_reps_c, err_mark);

    err_mark = errors; // extra start while busy must be dropped
    for (int n = 0; n < poke_ops_c; n++) begin
      k   = $urandom_range(8);
      req = (k < 6) ? rand_req(shift_ops_c[k]) : rand_req(clmul_ops_c[k-6]);
      check_op(req, 0, 1'b1, res);
    end
    report_test("busy", poke_ops_c, err_mark);

    $display("summary: tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, sized on 60 cycles per op
  initial begin
    #(watchdog_ns_c);
    $display("watchdog expired, simulation did not finish in %0d ns", watchdog_ns_c);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* project.f */
hw/bitmanip_pkg.sv
hw/bitmanip_ctrl.sv
hw/bitmanip_shifter.sv
hw/bitmanip_clmul.sv
hw/bitmanip_alu.sv
hw/bitmanip_result.sv
hw/bitmanip_top.sv
test/tb_bitmanip.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, the status follows the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_bitmanip \
  -f project.f -o sim_bitmanip &&
  ./obj_dir/sim_bitmanip | tee /dev/stderr | grep -qx "Done: no errors" &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
